// File: src/sdram_cfg_pkg.sv
package sdram_cfg_pkg;

  parameter int addr_w            = 20;  // host word address
  parameter int data_w            = 16;
  parameter int line_words_log2   = 2;   // 4-word read line
  parameter int stream_words_log2 = 4;   // 16-word stream block
  parameter int burst_w           = 5;   // wide enough for 16

  typedef logic [addr_w-1:0]  addr_t;
  typedef logic [data_w-1:0]  data_t;
  typedef logic [burst_w-1:0] burst_t;

endpackage

// File: src/sdram_job_pkg.sv
package sdram_job_pkg;
  import sdram_cfg_pkg::*;

  typedef enum logic [1:0] {
    op_none         = 2'd0,
    op_line_read    = 2'd1,
    op_single_write = 2'd2,
    op_stream_flush = 2'd3
  } job_op_e;

  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_issue = 2'd1,  // request up, no ack yet
    st_beats = 2'd2,
    st_done  = 2'd3   // done pulse cycle
  } seq_state_e;

  // sequencer to controller
  typedef struct packed {
    logic   rd_req;
    logic   wr_req;
    addr_t  addr;
    burst_t burst;
    data_t  din;
    logic   hold_refresh;
  } ctrl_cmd_t;

  // controller back to sequencer
  typedef struct packed {
    logic  rd_ack;
    logic  wr_ack;
    data_t dout;
  } ctrl_rsp_t;

  typedef struct packed {
    logic  req;   // level, held until done
    addr_t addr;
  } job_req_t;

  typedef struct packed {
    logic                       valid;
    logic [line_words_log2-1:0] index;
    data_t                      data;
  } beat_t;

endpackage

// File: src/line_read_cache.sv
module line_read_cache
  import sdram_cfg_pkg::*;
  import sdram_job_pkg::*;
#(
  parameter int line_words_log2 = sdram_cfg_pkg::line_words_log2
) (
  input  logic     clk,
  input  logic     sys_rst_n,
  input  logic     read_req,
  input  addr_t    address,
  input  logic     invalidate,
  output job_req_t read_job,
  input  logic     read_done,
  input  beat_t    beat,
  output logic     read_ack,
  output data_t    data_out
);

  localparam int line_words = 1 << line_words_log2;
  localparam int tag_w      = addr_w - line_words_log2;

  logic                       read_req_last;
  logic                       read_edge;
  logic                       line_valid;
  logic [tag_w-1:0]           line_tag;
  logic [tag_w-1:0]           req_tag;
  logic [line_words_log2-1:0] word_sel;
  logic                       hit;
  data_t                      line_q [line_words];

  assign req_tag   = address[addr_w-1:line_words_log2];
  assign word_sel  = address[line_words_log2-1:0];
  assign read_edge = read_req && !read_req_last;
  assign hit       = line_valid && (line_tag == req_tag);

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      read_req_last <= 1'b0;
    end else begin
      read_req_last <= read_req;
    end
  end

  always_ff @(posedge clk) begin
    if (beat.valid) begin
      line_q[beat.index] <= beat.data;  // fill in beat order
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      read_job   <= '0;
      line_valid <= 1'b0;
      line_tag   <= '0;
      read_ack   <= 1'b0;
      data_out   <= '0;
    end else begin
      if (read_edge) begin
        if (hit) begin
          read_ack <= 1'b1;
          data_out <= line_q[word_sel];
        end else begin
          line_valid    <= 1'b0;
          read_job.req  <= 1'b1;
          read_job.addr <= {req_tag, {line_words_log2{1'b0}}};  // line aligned
        end
      end else if (read_done) begin
        read_job.req <= 1'b0;
        line_valid   <= 1'b1;
        line_tag     <= read_job.addr[addr_w-1:line_words_log2];
        read_ack     <= 1'b1;
        data_out     <= line_q[word_sel];
      end else if (!read_req) begin
        read_ack <= 1'b0;  // host let go
        data_out <= '0;
      end
      if (invalidate) begin
        line_valid <= 1'b0;  // any host write may hit the line
      end
    end
  end

  a_ack_follows_req: assert property (@(posedge clk) disable iff (!sys_rst_n)
    read_ack |-> $past(read_req));

endmodule

// File: src/host_write_port.sv
module host_write_port
  import sdram_cfg_pkg::*;
  import sdram_job_pkg::*;
#(
  parameter int stream_words_log2 = sdram_cfg_pkg::stream_words_log2
) (
  input  logic     clk,
  input  logic     sys_rst_n,
  input  logic     write_req,
  input  logic     write_latch_address,
  input  logic     write_en,
  input  addr_t    address,
  input  data_t    data_in,
  output job_req_t single_job,
  input  logic     single_done,
  output data_t    single_data,
  output job_req_t flush_job,
  input  logic     flush_done,
  input  burst_t   beat_index,
  output data_t    flush_data,
  output logic     write_ack,
  output logic     invalidate
);

  localparam int stream_words = 1 << stream_words_log2;

  logic  write_req_last;
  logic  write_edge;
  addr_t stream_addr;
  addr_t stream_cur;  // address of this cycle's word
  logic  block_end;
  data_t front_buf [stream_words];
  data_t back_buf  [stream_words];

  assign write_edge = write_req && !write_req_last;
  assign stream_cur = write_latch_address ? address : stream_addr;
  assign block_end  = write_en && (&stream_cur[stream_words_log2-1:0]);
  assign invalidate = write_edge || write_en;
  assign flush_data = back_buf[beat_index[stream_words_log2-1:0]];

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      write_req_last <= 1'b0;
      single_job     <= '0;
      write_ack      <= 1'b0;
    end else begin
      write_req_last <= write_req;
      write_ack      <= 1'b0;
      if (write_edge) begin
        single_job.req  <= 1'b1;
        single_job.addr <= address;
      end else if (single_done) begin
        single_job.req <= 1'b0;
        write_ack      <= 1'b1;  // one-cycle pulse
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write_edge) begin
      single_data <= data_in;
    end
  end

  // stream address, steps once per word
  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      stream_addr <= '0;
    end else if (write_en) begin
      stream_addr <= stream_cur + 1'b1;
    end else begin
      stream_addr <= stream_cur;
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      flush_job <= '0;
    end else begin
      if (flush_done) begin
        flush_job.req <= 1'b0;
      end
      if (block_end) begin
        flush_job.req  <= 1'b1;
        flush_job.addr <= {stream_cur[addr_w-1:stream_words_log2],
                           {stream_words_log2{1'b0}}};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      front_buf[stream_cur[stream_words_log2-1:0]] <= data_in;
    end
    if (block_end) begin
      for (int i = 0; i < stream_words - 1; i++) begin
        back_buf[i] <= front_buf[i];
      end
      back_buf[stream_words-1] <= data_in;  // last word skips front
    end
  end

  // back buffer is still being burst out until flush_done
  a_no_swap_while_pending: assert property (@(posedge clk) disable iff (!sys_rst_n)
    block_end |-> (!flush_job.req || flush_done));

endmodule

// File: src/burst_sequencer.sv
module burst_sequencer
  import sdram_cfg_pkg::*;
  import sdram_job_pkg::*;
#(
  parameter int line_words_log2   = sdram_cfg_pkg::line_words_log2,
  parameter int stream_words_log2 = sdram_cfg_pkg::stream_words_log2
) (
  input  logic      clk,
  input  logic      sys_rst_n,
  input  job_req_t  read_job,
  input  job_req_t  single_job,
  input  job_req_t  flush_job,
  input  data_t     single_data,
  input  data_t     flush_data,
  input  logic      write_en,
  output logic      read_done,
  output logic      single_done,
  output logic      flush_done,
  output beat_t     beat,
  output burst_t    beat_index,
  output logic      busy,
  output ctrl_cmd_t ctrl_cmd,
  input  ctrl_rsp_t ctrl_rsp
);

  localparam burst_t line_burst   = burst_t'(1 << line_words_log2);
  localparam burst_t stream_burst = burst_t'(1 << stream_words_log2);

  seq_state_e state;
  job_op_e    op;
  burst_t     count;  // beats acked so far
  logic       rd_req_q;
  logic       wr_req_q;
  addr_t      addr_q;
  burst_t     burst_q;
  logic       ack;
  logic       last_beat;

  assign ack        = (op == op_line_read) ? ctrl_rsp.rd_ack : ctrl_rsp.wr_ack;
  assign last_beat  = ack && (count == burst_q - 1'b1);
  assign beat_index = count;
  assign busy       = (state != st_idle);

  assign read_done   = (state == st_done) && (op == op_line_read);
  assign single_done = (state == st_done) && (op == op_single_write);
  assign flush_done  = (state == st_done) && (op == op_stream_flush);

  // read beats go straight to the line buffer
  always_comb begin
    beat.valid = ctrl_rsp.rd_ack && (op == op_line_read)
                 && (state == st_issue || state == st_beats);
    beat.index = count[line_words_log2-1:0];
    beat.data  = ctrl_rsp.dout;
  end

  always_comb begin
    ctrl_cmd.rd_req       = rd_req_q;
    ctrl_cmd.wr_req       = wr_req_q;
    ctrl_cmd.addr         = addr_q;
    ctrl_cmd.burst        = burst_q;
    ctrl_cmd.din          = (op == op_single_write) ? single_data : flush_data;
    ctrl_cmd.hold_refresh = write_en;  // no refresh mid-stream
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state    <= st_idle;
      op       <= op_none;
      count    <= '0;
      rd_req_q <= 1'b0;
      wr_req_q <= 1'b0;
      addr_q   <= '0;
      burst_q  <= '0;
    end else begin
      case (state)
        st_idle: begin
          count <= '0;
          if (read_job.req) begin  // fixed priority
            op       <= op_line_read;
            rd_req_q <= 1'b1;
            addr_q   <= read_job.addr;
            burst_q  <= line_burst;
            state    <= st_issue;
          end else if (single_job.req) begin
            op       <= op_single_write;
            wr_req_q <= 1'b1;
            addr_q   <= single_job.addr;
            burst_q  <= burst_t'(1);
            state    <= st_issue;
          end else if (flush_job.req) begin
            op       <= op_stream_flush;
            wr_req_q <= 1'b1;
            addr_q   <= flush_job.addr;
            burst_q  <= stream_burst;
            state    <= st_issue;
          end
        end
        st_issue, st_beats: begin
          if (ack) begin
            count <= count + 1'b1;
            state <= st_beats;
          end
          if (last_beat) begin
            rd_req_q <= 1'b0;
            wr_req_q <= 1'b0;
            state    <= st_done;
          end
        end
        st_done: begin
          op    <= op_none;
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  a_one_direction: assert property (@(posedge clk) disable iff (!sys_rst_n)
    !(ctrl_cmd.rd_req && ctrl_cmd.wr_req));

endmodule

// File: src/sdram_front_top.sv
module sdram_front_top
  import sdram_cfg_pkg::*;
  import sdram_job_pkg::*;
#(
  parameter int line_words_log2   = sdram_cfg_pkg::line_words_log2,
  parameter int stream_words_log2 = sdram_cfg_pkg::stream_words_log2
) (
  input  logic      clk,
  input  logic      sys_rst_n,
  input  logic      read_req,
  input  logic      write_req,
  input  logic      write_latch_address,
  input  logic      write_en,
  input  addr_t     address,
  input  data_t     data_in,
  output data_t     data_out,
  output logic      read_ack,
  output logic      write_ack,
  output logic      busy,
  output ctrl_cmd_t ctrl_cmd,
  input  ctrl_rsp_t ctrl_rsp
);

  job_req_t read_job;
  job_req_t single_job;
  job_req_t flush_job;
  logic     read_done;
  logic     single_done;
  logic     flush_done;
  logic     invalidate;
  beat_t    beat;
  burst_t   beat_index;
  data_t    single_data;
  data_t    flush_data;

  line_read_cache #(
    .line_words_log2 (line_words_log2)
  ) u_line_read_cache (
    .clk        (clk),
    .sys_rst_n  (sys_rst_n),
    .read_req   (read_req),
    .address    (address),
    .invalidate (invalidate),
    .read_job   (read_job),
    .read_done  (read_done),
    .beat       (beat),
    .read_ack   (read_ack),
    .data_out   (data_out)
  );

  host_write_port #(
    .stream_words_log2 (stream_words_log2)
  ) u_host_write_port (
    .clk                 (clk),
    .sys_rst_n           (sys_rst_n),
    .write_req           (write_req),
    .write_latch_address (write_latch_address),
    .write_en            (write_en),
    .address             (address),
    .data_in             (data_in),
    .single_job          (single_job),
    .single_done         (single_done),
    .single_data         (single_data),
    .flush_job           (flush_job),
    .flush_done          (flush_done),
    .beat_index          (beat_index),
    .flush_data          (flush_data),
    .write_ack           (write_ack),
    .invalidate          (invalidate)
  );

  burst_sequencer #(
    .line_words_log2   (line_words_log2),
    .stream_words_log2 (stream_words_log2)
  ) u_burst_sequencer (
    .clk         (clk),
    .sys_rst_n   (sys_rst_n),
    .read_job    (read_job),
    .single_job  (single_job),
    .flush_job   (flush_job),
    .single_data (single_data),
    .flush_data  (flush_data),
    .write_en    (write_en),
    .read_done   (read_done),
    .single_done (single_done),
    .flush_done  (flush_done),
    .beat        (beat),
    .beat_index  (beat_index),
    .busy        (busy),
    .ctrl_cmd    (ctrl_cmd),
    .ctrl_rsp    (ctrl_rsp)
  );

endmodule

// File: sim/ctrl_model.sv
module ctrl_model
  import sdram_cfg_pkg::*;
  import sdram_job_pkg::*;
(
  input  logic      clk,
  input  logic      sys_rst_n,
  input  ctrl_cmd_t ctrl_cmd,
  output ctrl_rsp_t ctrl_rsp
);

  integer seed = 32'h823c;
  data_t  mem [addr_t];  // sparse, unwritten words read the fill pattern
  logic   active;
  logic   wait_low;      // burst finished, request still up
  logic   is_read;
  addr_t  base;
  int     len;
  int     sent;          // acks issued so far
  int     gap;

  function automatic data_t fill_word(input addr_t a);
    return data_t'(a ^ (a >> 4));
  endfunction

  function automatic data_t read_word(input addr_t a);
    return mem.exists(a) ? mem[a] : fill_word(a);
  endfunction

  always @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      ctrl_rsp <= '0;
      active   = 1'b0;
      wait_low = 1'b0;
      is_read  = 1'b0;
      base     = '0;
      len      = 0;
      sent     = 0;
      gap      = 0;
    end else begin
      if (ctrl_rsp.wr_ack) begin
        mem[base + addr_t'(sent - 1)] = ctrl_cmd.din;  // word of the beat just acked
      end
      ctrl_rsp <= '0;
      if (wait_low && !ctrl_cmd.rd_req && !ctrl_cmd.wr_req) begin
        wait_low = 1'b0;
      end
      if (!active && !wait_low && (ctrl_cmd.rd_req || ctrl_cmd.wr_req)) begin
        active  = 1'b1;
        is_read = ctrl_cmd.rd_req;
        base    = ctrl_cmd.addr;
        len     = int'(ctrl_cmd.burst);
        sent    = 0;
        gap     = 1 + ($random(seed) & 3);  // first ack latency
      end else if (active) begin
        if (gap > 0) begin
          gap--;
        end else begin
          ctrl_rsp.rd_ack <= is_read;
          ctrl_rsp.wr_ack <= !is_read;
          ctrl_rsp.dout   <= is_read ? read_word(base + addr_t'(sent)) : '0;
          sent++;
          gap = $random(seed) & 1;  // holes between acks
          if (sent == len) begin
            active   = 1'b0;
            wait_low = 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: sim/tb_sdram_front.sv
module tb_sdram_front
  import sdram_cfg_pkg::*;
  import sdram_job_pkg::*;
;

  localparam int     stream_len   = 1 << stream_words_log2;
  localparam burst_t line_burst   = burst_t'(1 << line_words_log2);
  localparam burst_t stream_burst = burst_t'(stream_len);
  localparam burst_t single_burst = burst_t'(1);
  localparam int     jobs_planned = 30;  // rough job count of the sequence below
  localparam int     max_cycles   = jobs_planned * 100 + 1000;

  logic      clk;
  logic      sys_rst_n;
  logic      read_req;
  logic      write_req;
  logic      write_latch_address;
  logic      write_en;
  addr_t     address;
  data_t     data_in;
  data_t     data_out;
  logic      read_ack;
  logic      write_ack;
  logic      busy;
  ctrl_cmd_t ctrl_cmd;
  ctrl_rsp_t ctrl_rsp;

  integer seed = 32'h823c;
  int     errors;
  int     reads;
  int     hits;
  int     writes;
  int     streams;
  int     flush_count;
  int     cycles;

  data_t  mirror [addr_t];  // host view of memory
  data_t  stream_exp [stream_len];
  data_t  stream_word;
  addr_t  stream_base;
  data_t  exp_data;
  data_t  single_exp;
  addr_t  single_addr;
  logic   expect_hit;
  logic   host_started;
  logic   fetch_seen;
  logic   wr_req_d;
  logic   [stream_words_log2-1:0] wr_beats;
  logic   cached_valid;
  logic   [addr_w-line_words_log2-1:0] cached_line;

  sdram_front_top #(
    .line_words_log2   (line_words_log2),
    .stream_words_log2 (stream_words_log2)
  ) u_dut (
    .clk                 (clk),
    .sys_rst_n           (sys_rst_n),
    .read_req            (read_req),
    .write_req           (write_req),
    .write_latch_address (write_latch_address),
    .write_en            (write_en),
    .address             (address),
    .data_in             (data_in),
    .data_out            (data_out),
    .read_ack            (read_ack),
    .write_ack           (write_ack),
    .busy                (busy),
    .ctrl_cmd            (ctrl_cmd),
    .ctrl_rsp            (ctrl_rsp)
  );

  ctrl_model u_ctrl_model (
    .clk       (clk),
    .sys_rst_n (sys_rst_n),
    .ctrl_cmd  (ctrl_cmd),
    .ctrl_rsp  (ctrl_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  assign stream_word = stream_exp[wr_beats];

  always @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wr_beats    <= '0;
      wr_req_d    <= 1'b0;
      fetch_seen  <= 1'b0;
      flush_count <= 0;
    end else begin
      wr_req_d <= ctrl_cmd.wr_req;
      if (ctrl_rsp.wr_ack) begin
        wr_beats <= wr_beats + 1'b1;
      end else if (!ctrl_cmd.wr_req) begin
        wr_beats <= '0;
      end
      if (ctrl_cmd.wr_req && !wr_req_d && ctrl_cmd.burst == stream_burst) begin
        flush_count <= flush_count + 1;
      end
      if (!read_req) begin
        fetch_seen <= 1'b0;
      end else if (ctrl_cmd.rd_req) begin
        fetch_seen <= 1'b1;  // line fetch during this read
      end
    end
  end

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!sys_rst_n)
    !host_started |-> !(read_ack || write_ack || busy || ctrl_cmd.rd_req || ctrl_cmd.wr_req))
    else begin
      errors++;
      $display("outputs became active at %0t before any host request", $time);
    end

  a_read_data: assert property (@(posedge clk) disable iff (!sys_rst_n)
    read_ack |-> data_out == exp_data)
    else begin
      errors++;
      $display("mismatch at %0t: data_out got %h expected %h",
               $time, $sampled(data_out), $sampled(exp_data));
    end

  a_hit_timing: assert property (@(posedge clk) disable iff (!sys_rst_n)
    $rose(read_req) && expect_hit |=> read_ack && !ctrl_cmd.rd_req)
    else begin
      errors++;
      $display("read hit at %0t was not answered one cycle after the request", $time);
    end

  a_miss_fetch: assert property (@(posedge clk) disable iff (!sys_rst_n)
    $rose(read_ack) && !expect_hit |-> fetch_seen)
    else begin
      errors++;
      $display("read miss at %0t was answered without a line fetch", $time);
    end

  a_busy_cover: assert property (@(posedge clk) disable iff (!sys_rst_n)
    (ctrl_cmd.rd_req || ctrl_cmd.wr_req) |-> busy)
    else begin
      errors++;
      $display("controller request at %0t while busy was low", $time);
    end

  a_read_burst: assert property (@(posedge clk) disable iff (!sys_rst_n)
    ctrl_cmd.rd_req |-> ctrl_cmd.burst == line_burst
                        && ctrl_cmd.addr[line_words_log2-1:0] == '0)
    else begin
      errors++;
      $display("line read at %0t has a wrong burst length or an unaligned address", $time);
    end

  a_single_addr: assert property (@(posedge clk) disable iff (!sys_rst_n)
    ctrl_cmd.wr_req && ctrl_cmd.burst == single_burst |-> ctrl_cmd.addr == single_addr)
    else begin
      errors++;
      $display("mismatch at %0t: ctrl_cmd.addr got %h expected %h",
               $time, $sampled(ctrl_cmd.addr), $sampled(single_addr));
    end

  a_single_din: assert property (@(posedge clk) disable iff (!sys_rst_n)
    ctrl_rsp.wr_ack && ctrl_cmd.burst == single_burst |-> ctrl_cmd.din == single_exp)
    else begin
      errors++;
      $display("mismatch at %0t: ctrl_cmd.din got %h expected %h",
               $time, $sampled(ctrl_cmd.din), $sampled(single_exp));
    end

  a_stream_addr: assert property (@(posedge clk) disable iff (!sys_rst_n)
    ctrl_cmd.wr_req && ctrl_cmd.burst == stream_burst |-> ctrl_cmd.addr == stream_base)
    else begin
      errors++;
      $display("mismatch at %0t: ctrl_cmd.addr got %h expected %h",
               $time, $sampled(ctrl_cmd.addr), $sampled(stream_base));
    end

  a_stream_din: assert property (@(posedge clk) disable iff (!sys_rst_n)
    ctrl_rsp.wr_ack && ctrl_cmd.burst == stream_burst |-> ctrl_cmd.din == stream_word)
    else begin
      errors++;
      $display("mismatch at %0t: ctrl_cmd.din got %h expected %h",
               $time, $sampled(ctrl_cmd.din), $sampled(stream_word));
    end

  a_hold_refresh: assert property (@(posedge clk) disable iff (!sys_rst_n)
    ctrl_cmd.hold_refresh == write_en)
    else begin
      errors++;
      $display("mismatch at %0t: ctrl_cmd.hold_refresh got %b expected %b",
               $time, $sampled(ctrl_cmd.hold_refresh), $sampled(write_en));
    end

  function automatic data_t fill_word(input addr_t a);
    return data_t'(a ^ (a >> 4));  // preload of the controller model
  endfunction

  function automatic data_t expected_word(input addr_t a);
    return mirror.exists(a) ? mirror[a] : fill_word(a);
  endfunction

  task automatic finish_run;
    $display("errors %0d, reads %0d (hits %0d), single writes %0d, streams %0d, bursts %0d",
             errors, reads, hits, writes, streams, flush_count);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  task automatic single_write(input addr_t a, input data_t d);
    @(posedge clk);
    write_req    <= 1'b1;
    address      <= a;
    data_in      <= d;
    single_exp   <= d;
    single_addr  <= a;
    host_started <= 1'b1;
    do @(posedge clk); while (!write_ack);
    write_req <= 1'b0;
    mirror[a]    = d;
    cached_valid = 1'b0;  // any write drops the line
    writes++;
  endtask

  task automatic host_read(input addr_t a);
    logic hit;
    hit = cached_valid && (a[addr_w-1:line_words_log2] == cached_line);
    @(posedge clk);
    read_req     <= 1'b1;
    address      <= a;
    expect_hit   <= hit;
    exp_data     <= expected_word(a);
    host_started <= 1'b1;
    do @(posedge clk); while (!read_ack);
    read_req <= 1'b0;
    do @(posedge clk); while (read_ack);
    cached_valid = 1'b1;
    cached_line  = a[addr_w-1:line_words_log2];
    reads++;
    if (hit) begin
      hits++;
    end
  endtask

  task automatic stream_block(input addr_t base);
    data_t w;
    @(posedge clk);
    write_latch_address <= 1'b1;
    address             <= base;
    stream_base         <= base;
    host_started        <= 1'b1;
    for (int i = 0; i < stream_len; i++) begin
      w = data_t'($random(seed));
      @(posedge clk);
      write_latch_address <= 1'b0;
      write_en            <= 1'b1;
      data_in             <= w;
      stream_exp[i]       <= w;
      mirror[base + addr_t'(i)] = w;
    end
    @(posedge clk);
    write_en <= 1'b0;
    do @(posedge clk); while (!busy);
    do @(posedge clk); while (busy);  // flush finished
    cached_valid = 1'b0;
    streams++;
  endtask

  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    errors++;
    $display("run did not finish within %0d cycles", max_cycles);
    finish_run();
  end

  initial begin
    addr_t a;
    data_t d;
    read_req            = 1'b0;
    write_req           = 1'b0;
    write_latch_address = 1'b0;
    write_en            = 1'b0;
    address             = '0;
    data_in             = '0;
    host_started        = 1'b0;
    expect_hit          = 1'b0;
    exp_data            = '0;
    single_exp          = '0;
    single_addr         = '0;
    stream_base         = '0;
    cached_valid        = 1'b0;
    cached_line         = '0;
    errors              = 0;
    reads               = 0;
    hits                = 0;
    writes              = 0;
    streams             = 0;
    sys_rst_n           = 1'b0;
    repeat (8) @(posedge clk);
    sys_rst_n <= 1'b1;
    repeat (6) @(posedge clk);  // quiet window

    single_write(20'h00105, 16'hbeef);
    host_read(20'h00105);
    host_read(20'h00106);
    host_read(20'h00104);

    stream_block(20'h00200);
    for (int i = 0; i < 8; i++) begin
      host_read(20'h00200 + addr_t'(i));
    end

    host_read(20'h00300);
    host_read(20'h00301);
    single_write(20'h00302, 16'h1234);  // line must be fetched again
    host_read(20'h00302);

    for (int k = 0; k < 6; k++) begin
      a = addr_t'(32'h400 + ($random(seed) & 32'h3f));
      d = data_t'($random(seed));
      single_write(a, d);
      host_read(a);
      host_read(a ^ 20'h1);
    end

    stream_block(20'h00410);
    host_read(20'h0041f);
    host_read(20'h0041c);
    host_read(20'h00415);
    repeat (4) @(posedge clk);

    assert (flush_count == streams)
      else begin
        errors++;
        $display("mismatch at %0t: flush_count got %0d expected %0d",
                 $time, flush_count, streams);
      end
    finish_run();
  end

endmodule

// File: list.f
src/sdram_cfg_pkg.sv
src/sdram_job_pkg.sv
src/line_read_cache.sv
src/host_write_port.sv
src/burst_sequencer.sv
src/sdram_front_top.sv
sim/ctrl_model.sv
sim/tb_sdram_front.sv

// File: Makefile
# Verilator flow for the SDRAM front end

VERILATOR ?= verilator
TOP       ?= tb_sdram_front
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
